// ==== Bender.yml ====
package:
  name: cart_loader

sources:
  - sms_loader_pkg.sv
  - dl_port.sv
  - cart_config.sv
  - cheat_code_asm.sv
  - rom_store.sv
  - cart_loader_top.sv
  - target: test
    files:
      - cart_loader_asserts.sv
      - tb_cart_loader.sv

// ==== cart_config.sv ====
`timescale 1ns/10ps

module cart_config (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  sms_loader_pkg::dl_beat_t   beat,
	input  logic                       dl_end,
	output sms_loader_pkg::cart_info_t cart_info,
	output sms_loader_pkg::byte_t      sysmode,
	output sms_loader_pkg::dsw_bank_t  dsw
);
	import sms_loader_pkg::*;

	dl_addr_t byte_count;   // Last cart address plus one
	dl_addr_t addr_hdr;
	logic     cart_wr;
	logic     sysmode_wr;
	logic     dsw_wr;

	assign addr_hdr   = beat.addr - dl_addr_t'(HEADER_BYTES);
	assign cart_wr    = beat.valid && beat.kind == BEAT_CART;
	assign sysmode_wr = beat.valid && beat.kind == BEAT_SYSMODE;
	assign dsw_wr     = beat.valid && beat.kind == BEAT_DSW;

	// ==============================
	// Cartridge masks and flags
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_info  <= '0;
			byte_count <= '0;
		end else begin
			if (cart_wr) begin
				// First byte restarts the mask
				if (beat.addr == '0) cart_info.mask <= beat.addr[ROM_AW-1:0];
				else cart_info.mask <= cart_info.mask | beat.addr[ROM_AW-1:0];

				// Same again, seen past the header
				if (beat.addr == dl_addr_t'(HEADER_BYTES)) begin
					cart_info.mask512 <= '0;
				end else begin
					cart_info.mask512 <= cart_info.mask512 | addr_hdr[ROM_AW-1:0];
				end

				byte_count           <= beat.addr + 1'b1;
				cart_info.is_gg      <= beat.is_gg;
				cart_info.is_systeme <= 1'b0;
			end
			if (sysmode_wr) cart_info.is_systeme <= 1'b1;
			if (dl_end) cart_info.has_header <= byte_count[9];   // Odd 512-byte multiple
		end
	end

	// SYSMODE and DIP bytes
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			sysmode <= '0;
			dsw     <= '0;
		end else begin
			if (sysmode_wr) sysmode <= beat.data;
			if (dsw_wr) dsw[{beat.addr[1:0], 3'b000} +: 8] <= beat.data;
		end
	end

endmodule

// ==== cart_loader.f ====
sms_loader_pkg.sv
dl_port.sv
cart_config.sv
cheat_code_asm.sv
rom_store.sv
cart_loader_top.sv
cart_loader_asserts.sv
tb_cart_loader.sv

// ==== cart_loader_asserts.sv ====
`timescale 1ns/10ps

module cart_loader_asserts (
	input logic clk_sys,
	input logic arst_n,
	input logic stb,
	input logic ack,
	input logic rom_req,
	input logic rom_ack
);

	int fails;   // Failed assertion attempts

	// ==============================
	// Wishbone handshake
	// ==============================
	ack_needs_stb: assert property (
		@(posedge clk_sys) disable iff (!arst_n) ack |-> stb
	) else begin
		$error("wb_ack raised without a strobe");
		fails++;
	end

	ack_single: assert property (
		@(posedge clk_sys) disable iff (!arst_n) ack |=> !ack
	) else begin
		$error("wb_ack high for more than one cycle");
		fails++;
	end

	// A strobe only ends after its ack
	stb_ends_acked: assert property (
		@(posedge clk_sys) disable iff (!arst_n) $fell(stb) |-> $past(ack)
	) else begin
		$error("strobe dropped without an ack");
		fails++;
	end

	// ==============================
	// ROM toggle handshake
	// ==============================
	rom_ack_matches: assert property (
		@(posedge clk_sys) disable iff (!arst_n)
		!$stable(rom_ack) |-> (rom_ack == rom_req) && $past(rom_ack != rom_req)
	) else begin
		$error("rom_ack changed with no pending request");
		fails++;
	end

endmodule

bind dl_port cart_loader_asserts u_asserts (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.stb     (wb.cyc && wb.stb),
	.ack     (wb_ack),
	.rom_req (rom_wr.req),
	.rom_ack (rom_ack)
);

// ==== cart_loader_top.sv ====
`timescale 1ns/10ps

module cart_loader_top (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	input  sms_loader_pkg::wb_req_t     wb,
	output logic                        wb_ack,
	input  logic                        dl_active,
	input  sms_loader_pkg::byte_t       dl_index,
	input  sms_loader_pkg::rom_addr_t   rd_addr,
	output sms_loader_pkg::byte_t       rd_data,
	output sms_loader_pkg::cart_info_t  cart_info,
	output sms_loader_pkg::byte_t       sysmode,
	output sms_loader_pkg::dsw_bank_t   dsw,
	output sms_loader_pkg::cheat_code_t cheat,
	output logic                        cheat_valid
);
	import sms_loader_pkg::*;

	dl_beat_t beat;
	logic     dl_end;
	rom_wr_t  rom_wr;
	logic     rom_ack;

	// Host side
	dl_port u_dl_port (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.wb        (wb),
		.wb_ack    (wb_ack),
		.dl_active (dl_active),
		.dl_index  (dl_index),
		.beat      (beat),
		.dl_end    (dl_end),
		.rom_wr    (rom_wr),
		.rom_ack   (rom_ack)
	);

	cart_config u_cart_config (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.beat      (beat),
		.dl_end    (dl_end),
		.cart_info (cart_info),
		.sysmode   (sysmode),
		.dsw       (dsw)
	);

	cheat_code_asm u_cheat_code_asm (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.beat        (beat),
		.cheat       (cheat),
		.cheat_valid (cheat_valid)
	);

	// Core side
	rom_store u_rom_store (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.rom_wr    (rom_wr),
		.rom_ack   (rom_ack),
		.cart_info (cart_info),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

endmodule

// ==== cart_loader_trace.txt ====
# One command per line, fields in hex:
# F is_gg is_systeme has_header mask mask512 sysmode dsw | D index length base | R addr byte
# S sysmode | W dsw_addr byte | U index addr byte | C record b0..b15 flags addr compare replace
F 0 0 0 000 000 00 000000
D 01 400 30
F 0 0 0 3ff 1ff 00 000000
R 000 30
R 0ff 2f
R 3ff 2f
R 023 53
R 423 53
R 7c5 f5
D 02 600 81
F 1 0 1 7ff 3ff 00 000000
R 000 81
R 005 86
R 17e ff
R 1ff 80
R 2a0 21
S 5a
W 0 11
W 1 22
W 2 33
F 1 1 1 7ff 3ff 5a 332211
U 10 000 5a
U 04 001 77
U fe 003 44
F 1 1 1 7ff 3ff 5a 332211
D 01 400 c4
F 0 0 0 3ff 1ff 5a 332211
R 010 d4
R 610 d4
R 3ff c3
C 0 01 00 00 00 34 12 00 00 aa bb cc dd 78 56 34 12 00000001 00001234 ddccbbaa 12345678
C 1 02 00 00 80 ef be 00 00 11 22 33 44 fe ca ad de 80000002 0000beef 44332211 deadcafe
U 33 010 99
R 000 c4

// ==== cheat_code_asm.sv ====
`timescale 1ns/10ps

module cheat_code_asm (
	input  logic                        clk_sys,
	input  logic                        arst_n,
	input  sms_loader_pkg::dl_beat_t    beat,
	output sms_loader_pkg::cheat_code_t cheat,
	output logic                        cheat_valid
);
	import sms_loader_pkg::*;

	logic       cheat_wr;
	logic [4:0] lane;   // Bit offset inside the 32-bit field

	assign cheat_wr = beat.valid && beat.kind == BEAT_CHEAT;
	assign lane     = {beat.addr[1:0], 3'b000};

	// ==============================
	// Record assembly
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (cheat_wr) begin
			case (beat.addr[3:2])
				2'd0: cheat.flags[lane +: 8]   <= beat.data;
				2'd1: cheat.addr[lane +: 8]    <= beat.data;
				2'd2: cheat.compare[lane +: 8] <= beat.data;
				default: cheat.replace[lane +: 8] <= beat.data;
			endcase
		end
	end

	// Byte 15 closes the record
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= cheat_wr && (beat.addr[3:0] == 4'hf);
		end
	end

endmodule

// ==== dl_port.sv ====
`timescale 1ns/10ps

module dl_port (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  sms_loader_pkg::wb_req_t  wb,
	output logic                     wb_ack,
	input  logic                     dl_active,
	input  sms_loader_pkg::byte_t    dl_index,
	output sms_loader_pkg::dl_beat_t beat,
	output logic                     dl_end,
	output sms_loader_pkg::rom_wr_t  rom_wr,
	input  logic                     rom_ack
);
	import sms_loader_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_WAIT_ROM, ST_ACK} state_t;

	state_t     state;
	beat_kind_t kind;
	logic       accept;
	logic       rom_req;
	rom_addr_t  rom_addr;
	byte_t      rom_data;
	logic       dl_active_q;
	logic       cart_dl;   // Cart beats seen in this download

	// ==============================
	// Beat classification
	// ==============================
	always_comb begin
		kind = BEAT_NONE;
		case (dl_index)
			IDX_SMS, IDX_GG: kind = BEAT_CART;
			IDX_SYSMODE: if (wb.adr == '0) kind = BEAT_SYSMODE;
			IDX_DSW: if (wb.adr < dl_addr_t'(DSW_COUNT)) kind = BEAT_DSW;
			IDX_CHEAT: kind = BEAT_CHEAT;
			default: kind = BEAT_NONE;   // Acked, then dropped
		endcase
	end

	assign accept = (state == ST_IDLE) && wb.cyc && wb.stb;

	assign beat.valid = accept;
	assign beat.kind  = kind;
	assign beat.is_gg = (dl_index == IDX_GG);
	assign beat.addr  = wb.adr;
	assign beat.data  = wb.dat;

	assign wb_ack = (state == ST_ACK);   // One cycle per strobe

	// ==============================
	// Host pacing FSM
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state   <= ST_IDLE;
			rom_req <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (accept) begin
					if (kind == BEAT_CART) begin
						state   <= ST_WAIT_ROM;
						rom_req <= ~rom_req;
					end else begin
						state <= ST_ACK;
					end
				end
				ST_WAIT_ROM: if (rom_ack == rom_req) state <= ST_ACK;
				ST_ACK: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Write payload follows the request toggle
	always_ff @(posedge clk_sys) begin
		if (accept && kind == BEAT_CART) begin
			rom_addr <= wb.adr[ROM_AW-1:0];
			rom_data <= wb.dat;
		end
	end

	assign rom_wr.req  = rom_req;
	assign rom_wr.addr = rom_addr;
	assign rom_wr.data = rom_data;

	// End of cartridge download
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			dl_active_q <= 1'b0;
			cart_dl     <= 1'b0;
			dl_end      <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			dl_end      <= dl_active_q && !dl_active && cart_dl;
			if (dl_active_q && !dl_active) cart_dl <= 1'b0;
			else if (accept && kind == BEAT_CART) cart_dl <= 1'b1;
		end
	end

endmodule

// ==== rom_store.sv ====
`timescale 1ns/10ps

module rom_store (
	input  logic                       clk_sys,
	input  logic                       arst_n,
	input  sms_loader_pkg::rom_wr_t    rom_wr,
	output logic                       rom_ack,
	input  sms_loader_pkg::cart_info_t cart_info,
	input  sms_loader_pkg::rom_addr_t  rd_addr,
	output sms_loader_pkg::byte_t      rd_data
);
	import sms_loader_pkg::*;

	byte_t     mem [2**ROM_AW];
	logic      req_seen;   // Last request taken
	logic      wr_en;
	rom_addr_t rd_idx;

	// ==============================
	// Write side
	// ==============================
	assign wr_en = (rom_wr.req != req_seen);   // New toggle pending

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			req_seen <= 1'b0;
			rom_ack  <= 1'b0;
		end else begin
			req_seen <= rom_wr.req;
			rom_ack  <= req_seen;   // Echo a cycle after the write
		end
	end

	always_ff @(posedge clk_sys) begin
		if (wr_en) mem[rom_wr.addr] <= rom_wr.data;
	end

	// ==============================
	// Read side
	// ==============================
	always_comb begin
		if (cart_info.has_header) begin
			// Skip the copier header
			rd_idx = (rd_addr + rom_addr_t'(HEADER_BYTES)) & cart_info.mask512;
		end else begin
			rd_idx = rd_addr & cart_info.mask;
		end
	end

	always_ff @(posedge clk_sys) begin
		rd_data <= mem[rd_idx];
	end

endmodule

// ==== sms_loader_pkg.sv ====
package sms_loader_pkg;

	// ==============================
	// Widths and sizes
	// ==============================
	localparam int ROM_AW       = 12;   // 4 KiB on-chip store
	localparam int HEADER_BYTES = 512;  // Copier header
	localparam int DSW_COUNT    = 3;

	typedef logic [7:0]             byte_t;
	typedef logic [24:0]            dl_addr_t;
	typedef logic [ROM_AW-1:0]      rom_addr_t;
	typedef logic [DSW_COUNT*8-1:0] dsw_bank_t;
	typedef logic [31:0]            word_t;

	// Download index values
	localparam byte_t IDX_SMS     = 8'd1;
	localparam byte_t IDX_GG      = 8'd2;
	localparam byte_t IDX_SYSMODE = 8'd4;
	localparam byte_t IDX_DSW     = 8'd254;
	localparam byte_t IDX_CHEAT   = 8'd255;

	// ==============================
	// Beat and bus types
	// ==============================
	typedef enum logic [2:0] {
		BEAT_NONE,
		BEAT_CART,
		BEAT_SYSMODE,
		BEAT_DSW,
		BEAT_CHEAT
	} beat_kind_t;

	typedef struct packed {
		logic       valid;
		beat_kind_t kind;
		logic       is_gg;
		dl_addr_t   addr;
		byte_t      data;
	} dl_beat_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		dl_addr_t adr;
		byte_t    dat;
	} wb_req_t;

	typedef struct packed {
		logic      is_gg;
		logic      is_systeme;
		logic      has_header;
		rom_addr_t mask;
		rom_addr_t mask512;
	} cart_info_t;

	// Fields are little-endian words
	typedef struct packed {
		word_t flags;
		word_t addr;
		word_t compare;
		word_t replace;
	} cheat_code_t;

	typedef struct packed {
		logic      req;   // Toggles once per write
		rom_addr_t addr;
		byte_t     data;
	} rom_wr_t;

endpackage

// ==== tb_cart_loader.sv ====
`timescale 1ns/10ps

module tb_cart_loader;
	import sms_loader_pkg::*;

	logic        clk_sys;
	logic        arst_n;
	wb_req_t     wb;
	logic        wb_ack;
	logic        dl_active;
	byte_t       dl_index;
	rom_addr_t   rd_addr;
	byte_t       rd_data;
	cart_info_t  cart_info;
	byte_t       sysmode;
	dsw_bank_t   dsw;
	cheat_code_t cheat;
	logic        cheat_valid;

	string       lines[$];     // Trace commands without comments
	int          cycle_limit;
	bit          limit_set;
	int          errors;
	int          test_errors;
	int          tests_failed;
	int          strobes;
	int          acks;
	int          cheat_pulses;
	cheat_code_t cheat_seen;   // Record held at its valid pulse

	cart_loader_top UUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// Monitors sample between rising edges
	always @(negedge clk_sys) begin
		if (wb_ack) acks++;
		if (cheat_valid) begin
			cheat_pulses++;
			cheat_seen = cheat;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		wait (limit_set);
		while (cycles < cycle_limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: the trace was still running after %0d cycles", cycles);
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [127:0] got,
		input logic [127:0] exp);
		$display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
		errors++;
		test_errors++;
	endtask

	// ==============================
	// Host side of the Wishbone port
	// ==============================
	task automatic wb_write(input dl_addr_t adr, input byte_t dat);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		wb = '{cyc: 1'b1, stb: 1'b1, adr: adr, dat: dat};
		strobes++;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!wb_ack && waited < 16);
		if (!wb_ack) begin
			$display("Beat at address %0h was never acknowledged", adr);
			errors++;
			test_errors++;
		end
		@(negedge clk_sys);   // Hold past the ack edge
		wb.cyc = 1'b0;
		wb.stb = 1'b0;
		repeat ($urandom % 4) @(negedge clk_sys);
	endtask

	task automatic open_download(input byte_t idx);
		@(negedge clk_sys);
		dl_index  = idx;
		dl_active = 1'b1;
	endtask

	task automatic close_download();
		@(negedge clk_sys);
		dl_active = 1'b0;
		repeat (3) @(negedge clk_sys);   // dl_end, then the header flag
	endtask

	task automatic load_trace(output bit ok);
		int          fd;
		string       line;
		byte_t       c;
		logic [31:0] idx;
		logic [31:0] len;
		int          beats;
		int          reads;
		ok = 1'b0;
		beats = 0;
		reads = 0;
		fd = $fopen("cart_loader_trace.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(line.len() - 1) == "\n")
					line = line.substr(0, line.len() - 2);
				if (line.len() > 0 && line.getc(0) != "#") begin
					lines.push_back(line);
					void'($sscanf(line, "%c %h %h", c, idx, len));
					case (c)
						"D": beats += int'(len);
						"C": beats += 16;
						"R": reads++;
						"F": ;
						default: beats++;
					endcase
				end
			end
			$fclose(fd);
			ok = 1'b1;
			cycle_limit = beats * 8 + reads * 4 + 200;
			limit_set = 1'b1;
		end
	endtask

	// ==============================
	// One trace command
	// ==============================
	task automatic run_line(input string line);
		byte_t       c;
		logic [31:0] f [21];
		cart_info_t  snap_info;
		byte_t       snap_sys;
		dsw_bank_t   snap_dsw;
		cheat_code_t snap_cheat;
		int          pulses;
		void'($sscanf(line,
			"%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
			c, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
			f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20]));
		case (c)
			"F": begin
				if (cart_info.is_gg !== f[0][0]) report_mismatch("is_gg", cart_info.is_gg, f[0]);
				if (cart_info.is_systeme !== f[1][0])
					report_mismatch("is_systeme", cart_info.is_systeme, f[1]);
				if (cart_info.has_header !== f[2][0])
					report_mismatch("has_header", cart_info.has_header, f[2]);
				if (cart_info.mask !== f[3][ROM_AW-1:0]) report_mismatch("mask", cart_info.mask, f[3]);
				if (cart_info.mask512 !== f[4][ROM_AW-1:0])
					report_mismatch("mask512", cart_info.mask512, f[4]);
				if (sysmode !== f[5][7:0]) report_mismatch("sysmode", sysmode, f[5]);
				if (dsw !== f[6][23:0]) report_mismatch("dsw", dsw, f[6]);
			end
			"D": begin
				open_download(byte_t'(f[0]));
				for (int a = 0; a < int'(f[1]); a++) wb_write(dl_addr_t'(a), byte_t'(f[2] + a));
				close_download();
			end
			"S": begin
				open_download(IDX_SYSMODE);
				wb_write('0, byte_t'(f[0]));
				close_download();
			end
			"W": begin
				open_download(IDX_DSW);
				wb_write(dl_addr_t'(f[0]), byte_t'(f[1]));
				close_download();
			end
			"U": begin
				snap_info  = cart_info;
				snap_sys   = sysmode;
				snap_dsw   = dsw;
				snap_cheat = cheat;
				pulses     = cheat_pulses;
				open_download(byte_t'(f[0]));
				wb_write(dl_addr_t'(f[1]), byte_t'(f[2]));
				close_download();
				if (cart_info !== snap_info) report_mismatch("cart_info", cart_info, snap_info);
				if (sysmode !== snap_sys) report_mismatch("sysmode", sysmode, snap_sys);
				if (dsw !== snap_dsw) report_mismatch("dsw", dsw, snap_dsw);
				if (cheat !== snap_cheat) report_mismatch("cheat", cheat, snap_cheat);
				if (cheat_pulses != pulses) report_mismatch("cheat_valid pulses", cheat_pulses, pulses);
			end
			"C": begin
				pulses = cheat_pulses;
				open_download(IDX_CHEAT);
				for (int i = 0; i < 16; i++) wb_write(dl_addr_t'(f[0] * 16 + i), byte_t'(f[1 + i]));
				close_download();
				if (cheat_pulses != pulses + 1)
					report_mismatch("cheat_valid pulses", cheat_pulses, pulses + 1);
				if (cheat_seen.flags !== f[17]) report_mismatch("cheat.flags", cheat_seen.flags, f[17]);
				if (cheat_seen.addr !== f[18]) report_mismatch("cheat.addr", cheat_seen.addr, f[18]);
				if (cheat_seen.compare !== f[19])
					report_mismatch("cheat.compare", cheat_seen.compare, f[19]);
				if (cheat_seen.replace !== f[20])
					report_mismatch("cheat.replace", cheat_seen.replace, f[20]);
			end
			"R": begin
				@(negedge clk_sys);
				rd_addr = rom_addr_t'(f[0]);
				@(negedge clk_sys);   // Registered read
				if (rd_data !== f[1][7:0]) report_mismatch("rd_data", rd_data, f[1]);
			end
			default: begin
				$display("Unknown command in the trace: %s", line);
				errors++;
				test_errors++;
			end
		endcase
	endtask

	initial begin
		bit trace_ok;
		void'($urandom(32'h04786516));
		wb        = '0;
		dl_active = 1'b0;
		dl_index  = '0;
		rd_addr   = '0;
		arst_n    = 1'b0;
		load_trace(trace_ok);
		repeat (3) @(negedge clk_sys);
		arst_n = 1'b1;
		if (!trace_ok) begin
			$display("Could not open cart_loader_trace.txt");
			$display("STATUS: FAIL");
		end else begin
			foreach (lines[i]) begin
				test_errors = 0;
				run_line(lines[i]);
				if (test_errors != 0) tests_failed++;
				$display("test %0d %s  %s", i + 1, (test_errors == 0) ? "ok    " : "failed",
					lines[i]);
			end
			// One ack for every strobe over the whole run
			test_errors = 0;
			if (acks != strobes) report_mismatch("wb_ack count", acks, strobes);
			if (UUT.u_dl_port.u_asserts.fails != 0) begin
				$display("Handshake assertions failed %0d times",
					UUT.u_dl_port.u_asserts.fails);
				errors++;
				test_errors++;
			end
			if (test_errors != 0) tests_failed++;
			$display("test %0d %s  %0d acks for %0d strobes", lines.size() + 1,
				(test_errors == 0) ? "ok    " : "failed", acks, strobes);
			$display("%0d tests, %0d failed, %0d errors", lines.size() + 1, tests_failed, errors);
			if (errors == 0) begin
				$display("STATUS: PASS");
			end else begin
				$display("STATUS: FAIL");
			end
		end
		$finish;
	end

endmodule
